//--- hw/bp2wb_pkg.sv
////////////////////////////////////////
// bp2wb package
// Widths, opcode and size encodings and
// the message structs shared by the
// memory command to Wishbone bridge
////////////////////////////////////////
package bp2wb_pkg;

   // Physical address, as on the Wishbone side
   localparam int addr_width_lp = 37;
   // One 64-bit data word per bus cycle
   localparam int data_width_lp = 64;
   localparam int sel_width_lp = data_width_lp / 8;
   // Byte offset inside a word
   localparam int offset_width_lp = $clog2(sel_width_lp);

   // Memory command opcodes, uncached only
   typedef enum logic [0:0]
   {
      e_mem_rd = 1'b0,
      e_mem_wr = 1'b1
   } mem_opcode_e;

   // Number of bytes is 2**code
   typedef enum logic [1:0]
   {
      e_size_1 = 2'd0,
      e_size_2 = 2'd1,
      e_size_4 = 2'd2,
      e_size_8 = 2'd3
   } mem_size_e;

   // Command from the cache side, write data in the low bytes
   typedef struct packed
   {
      mem_opcode_e                opcode;
      mem_size_e                  size;
      logic [addr_width_lp-1:0]   addr;
      logic [data_width_lp-1:0]   data;
   } mem_cmd_s;

   // Response back, read data zero-extended
   typedef struct packed
   {
      mem_opcode_e                opcode;
      mem_size_e                  size;
      logic [addr_width_lp-1:0]   addr;
      logic [data_width_lp-1:0]   data;
      logic                       err;
   } mem_resp_s;

   // Decoded bus request plus the command it came from
   typedef struct packed
   {
      logic [addr_width_lp-1:0]   adr;
      logic [data_width_lp-1:0]   dat;
      logic [sel_width_lp-1:0]    sel;
      logic                       we;
      mem_opcode_e                opcode;
      mem_size_e                  size;
      logic [addr_width_lp-1:0]   addr;
      logic                       misaligned;
   } wb_req_s;

   // Finished bus cycle, raw word as seen on dat_i
   typedef struct packed
   {
      mem_opcode_e                opcode;
      mem_size_e                  size;
      logic [addr_width_lp-1:0]   addr;
      logic [data_width_lp-1:0]   dat;
      logic                       err;
   } wb_done_s;

   // Bit mask covering the low bytes of a given size
   function automatic logic [data_width_lp-1:0] data_mask(mem_size_e size);
      logic [data_width_lp-1:0] mask;
      case (size)
         e_size_1: mask = 64'h0000_0000_0000_00ff;
         e_size_2: mask = 64'h0000_0000_0000_ffff;
         e_size_4: mask = 64'h0000_0000_ffff_ffff;
         default:  mask = 64'hffff_ffff_ffff_ffff;
      endcase
      return mask;
   endfunction

endpackage

//--- hw/bp2wb_decode.sv
////////////////////////////////////////
// bp2wb command decoder
// Checks alignment, builds byte selects
// and lane data, and buffers up to two
// Wishbone requests
////////////////////////////////////////
module bp2wb_decode
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,

   input  bp2wb_pkg::mem_cmd_s   mem_cmd_i,
   input  logic                  mem_cmd_v_i,
   output logic                  mem_cmd_ready_o,

   output bp2wb_pkg::wb_req_s    req_o,
   output logic                  req_v_o,
   input  logic                  req_yumi_i
);

   logic [bp2wb_pkg::offset_width_lp-1:0] offset;
   logic [bp2wb_pkg::offset_width_lp-1:0] low_mask;
   logic [bp2wb_pkg::sel_width_lp-1:0]    sel_base;
   logic [bp2wb_pkg::offset_width_lp+2:0] lane_shift;
   logic [bp2wb_pkg::data_width_lp-1:0]   wr_data;
   bp2wb_pkg::wb_req_s                    req_n;

   bp2wb_pkg::wb_req_s                    fifo_r [2];
   logic                                  wr_ptr_r;
   logic                                  rd_ptr_r;
   logic [1:0]                            count_r;
   logic                                  push;
   logic                                  pop;

   assign offset = mem_cmd_i.addr[bp2wb_pkg::offset_width_lp-1:0];
   // Byte offset to bit offset
   assign lane_shift = {offset, 3'b000};

   // Low address bits that must be zero, and the unshifted lanes
   always_comb
   begin
      case (mem_cmd_i.size)
         bp2wb_pkg::e_size_1:
         begin
            low_mask = 3'b000;
            sel_base = 8'b0000_0001;
         end
         bp2wb_pkg::e_size_2:
         begin
            low_mask = 3'b001;
            sel_base = 8'b0000_0011;
         end
         bp2wb_pkg::e_size_4:
         begin
            low_mask = 3'b011;
            sel_base = 8'b0000_1111;
         end
         default:
         begin
            low_mask = 3'b111;
            sel_base = 8'b1111_1111;
         end
      endcase
   end

   // Trim write data to the size, then move it up to its lanes
   assign wr_data = (mem_cmd_i.data & bp2wb_pkg::data_mask(mem_cmd_i.size)) << lane_shift;

   always_comb
   begin
      req_n.adr        = {mem_cmd_i.addr[bp2wb_pkg::addr_width_lp-1:bp2wb_pkg::offset_width_lp],
                          {bp2wb_pkg::offset_width_lp{1'b0}}};
      req_n.we         = (mem_cmd_i.opcode == bp2wb_pkg::e_mem_wr);
      // Reads put nothing on dat_o
      req_n.dat        = req_n.we ? wr_data : '0;
      req_n.sel        = sel_base << offset;
      req_n.opcode     = mem_cmd_i.opcode;
      req_n.size       = mem_cmd_i.size;
      req_n.addr       = mem_cmd_i.addr;
      req_n.misaligned = |(offset & low_mask);
   end

   // Two-entry FIFO
   assign mem_cmd_ready_o = (count_r != 2'd2);
   assign push            = mem_cmd_v_i & mem_cmd_ready_o;
   assign req_v_o         = (count_r != 2'd0);
   assign pop             = req_v_o & req_yumi_i;
   assign req_o           = fifo_r[rd_ptr_r];

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_r <= 1'b0;
         rd_ptr_r <= 1'b0;
         count_r  <= 2'd0;
      end
      else
      begin
         if (push)
            wr_ptr_r <= ~wr_ptr_r;
         if (pop)
            rd_ptr_r <= ~rd_ptr_r;
         // Push and pop in one cycle leaves the count alone
         count_r <= count_r + {1'b0, push} - {1'b0, pop};
      end
   end

   // Entries hold payload only
   always_ff @(posedge clk_i)
   begin
      if (push)
         fifo_r[wr_ptr_r] <= req_n;
   end

endmodule

//--- hw/bp2wb_execute.sv
////////////////////////////////////////
// bp2wb bus cycle engine
// Runs one Wishbone classic cycle per
// request and reports its completion
////////////////////////////////////////
module bp2wb_execute
(
   input  logic                                    clk_i,
   input  logic                                    rst_n_i,

   input  bp2wb_pkg::wb_req_s                      req_i,
   input  logic                                    req_v_i,
   output logic                                    req_yumi_o,

   input  logic                                    resp_full_i,
   output bp2wb_pkg::wb_done_s                     done_o,
   output logic                                    done_v_o,

   output logic [bp2wb_pkg::addr_width_lp-1:0]     wbm_adr_o,
   output logic [bp2wb_pkg::data_width_lp-1:0]     wbm_dat_o,
   output logic [bp2wb_pkg::sel_width_lp-1:0]      wbm_sel_o,
   output logic                                    wbm_we_o,
   output logic                                    wbm_stb_o,
   output logic                                    wbm_cyc_o,
   input  logic [bp2wb_pkg::data_width_lp-1:0]     wbm_dat_i,
   input  logic                                    wbm_ack_i,
   input  logic                                    wbm_err_i
);

   typedef enum logic [1:0]
   {
      e_idle   = 2'd0,
      e_bus    = 2'd1,
      e_report = 2'd2
   } state_e;

   state_e                                state_r;
   bp2wb_pkg::wb_req_s                    req_r;
   logic [bp2wb_pkg::data_width_lp-1:0]   dat_r;
   logic                                  err_r;
   logic                                  bus_active;
   logic                                  bus_end;

   // New work only when the response slot is free
   assign req_yumi_o = (state_r == e_idle) & req_v_i & ~resp_full_i;

   assign bus_active = (state_r == e_bus);
   // Slave ended the cycle
   assign bus_end    = bus_active & (wbm_ack_i | wbm_err_i);

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         state_r <= e_idle;
      else
      begin
         case (state_r)
            e_idle:
            begin
               // Misaligned requests never touch the bus
               if (req_yumi_o)
                  state_r <= req_i.misaligned ? e_report : e_bus;
            end
            e_bus:
            begin
               if (bus_end)
                  state_r <= e_report;
            end
            e_report:
               state_r <= e_idle;
            default:
               state_r <= e_idle;
         endcase
      end
   end

   // Request and result capture
   always_ff @(posedge clk_i)
   begin
      if (req_yumi_o)
      begin
         req_r <= req_i;
         dat_r <= '0;
         err_r <= req_i.misaligned;
      end
      else if (bus_end)
      begin
         dat_r <= wbm_dat_i;
         // err wins if both come back
         err_r <= wbm_err_i;
      end
   end

   // Bus fields come straight from the latched request, stable for the whole cycle
   assign wbm_adr_o = req_r.adr;
   assign wbm_dat_o = req_r.dat;
   assign wbm_sel_o = req_r.sel;
   assign wbm_we_o  = req_r.we & bus_active;
   assign wbm_cyc_o = bus_active;
   assign wbm_stb_o = bus_active;

   // Completion to the response builder
   assign done_v_o = (state_r == e_report);

   always_comb
   begin
      done_o.opcode = req_r.opcode;
      done_o.size   = req_r.size;
      done_o.addr   = req_r.addr;
      done_o.dat    = dat_r;
      done_o.err    = err_r;
   end

endmodule

//--- hw/bp2wb_result.sv
////////////////////////////////////////
// bp2wb response builder
// Moves read bytes down to bit zero and
// holds one response until it is taken
////////////////////////////////////////
module bp2wb_result
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,

   input  bp2wb_pkg::wb_done_s   done_i,
   input  logic                  done_v_i,
   output logic                  resp_full_o,

   output bp2wb_pkg::mem_resp_s  mem_resp_o,
   output logic                  mem_resp_v_o,
   input  logic                  mem_resp_yumi_i
);

   logic [bp2wb_pkg::offset_width_lp+2:0] lane_shift;
   logic [bp2wb_pkg::data_width_lp-1:0]   rd_shift;
   logic                                  keep_data;
   bp2wb_pkg::mem_resp_s                  resp_n;
   bp2wb_pkg::mem_resp_s                  resp_r;
   logic                                  resp_v_r;

   // Byte offset of the access, in bits
   assign lane_shift = {done_i.addr[bp2wb_pkg::offset_width_lp-1:0], 3'b000};
   assign rd_shift   = done_i.dat >> lane_shift;

   // Only good reads return data
   assign keep_data = (done_i.opcode == bp2wb_pkg::e_mem_rd) & ~done_i.err;

   always_comb
   begin
      resp_n.opcode = done_i.opcode;
      resp_n.size   = done_i.size;
      resp_n.addr   = done_i.addr;
      resp_n.data   = keep_data ? (rd_shift & bp2wb_pkg::data_mask(done_i.size)) : '0;
      resp_n.err    = done_i.err;
   end

   // One-entry holding register
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         resp_v_r <= 1'b0;
      else if (done_v_i)
         resp_v_r <= 1'b1;
      else if (mem_resp_yumi_i)
         resp_v_r <= 1'b0;
   end

   always_ff @(posedge clk_i)
   begin
      if (done_v_i)
         resp_r <= resp_n;
   end

   // Engine holds off while this is high
   assign resp_full_o  = resp_v_r;
   assign mem_resp_v_o = resp_v_r;
   assign mem_resp_o   = resp_r;

endmodule

//--- hw/bp2wb_bridge.sv
////////////////////////////////////////
// bp2wb bridge
// Memory command and response messages
// to Wishbone classic single cycles
////////////////////////////////////////
module bp2wb_bridge
(
   input  logic                                    clk_i,
   input  logic                                    rst_n_i,

   // Memory command in
   input  bp2wb_pkg::mem_cmd_s                     mem_cmd_i,
   input  logic                                    mem_cmd_v_i,
   output logic                                    mem_cmd_ready_o,

   // Memory response out
   output bp2wb_pkg::mem_resp_s                    mem_resp_o,
   output logic                                    mem_resp_v_o,
   input  logic                                    mem_resp_yumi_i,

   // Wishbone master
   output logic [bp2wb_pkg::addr_width_lp-1:0]     wbm_adr_o,
   output logic [bp2wb_pkg::data_width_lp-1:0]     wbm_dat_o,
   output logic [bp2wb_pkg::sel_width_lp-1:0]      wbm_sel_o,
   output logic                                    wbm_we_o,
   output logic                                    wbm_stb_o,
   output logic                                    wbm_cyc_o,
   input  logic [bp2wb_pkg::data_width_lp-1:0]     wbm_dat_i,
   input  logic                                    wbm_ack_i,
   input  logic                                    wbm_err_i
);

   // Decoder to engine
   bp2wb_pkg::wb_req_s    req;
   logic                  req_v;
   logic                  req_yumi;

   // Engine to response builder
   bp2wb_pkg::wb_done_s   done;
   logic                  done_v;
   logic                  resp_full;

   bp2wb_decode u_decode
   (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .mem_cmd_i        (mem_cmd_i),
      .mem_cmd_v_i      (mem_cmd_v_i),
      .mem_cmd_ready_o  (mem_cmd_ready_o),
      .req_o            (req),
      .req_v_o          (req_v),
      .req_yumi_i       (req_yumi)
   );

   bp2wb_execute u_execute
   (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .req_i            (req),
      .req_v_i          (req_v),
      .req_yumi_o       (req_yumi),
      .resp_full_i      (resp_full),
      .done_o           (done),
      .done_v_o         (done_v),
      .wbm_adr_o        (wbm_adr_o),
      .wbm_dat_o        (wbm_dat_o),
      .wbm_sel_o        (wbm_sel_o),
      .wbm_we_o         (wbm_we_o),
      .wbm_stb_o        (wbm_stb_o),
      .wbm_cyc_o        (wbm_cyc_o),
      .wbm_dat_i        (wbm_dat_i),
      .wbm_ack_i        (wbm_ack_i),
      .wbm_err_i        (wbm_err_i)
   );

   bp2wb_result u_result
   (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .done_i           (done),
      .done_v_i         (done_v),
      .resp_full_o      (resp_full),
      .mem_resp_o       (mem_resp_o),
      .mem_resp_v_o     (mem_resp_v_o),
      .mem_resp_yumi_i  (mem_resp_yumi_i)
   );

endmodule

//--- tests/bp2wb_chk.sv
////////////////////////////////////////
// bp2wb protocol checker
// Handshake and Wishbone classic rules
////////////////////////////////////////
module bp2wb_chk
(
   input  logic                                  clk_i,
   input  logic                                  rst_n_i,
   input  logic                                  mem_cmd_ready_o,
   input  bp2wb_pkg::mem_resp_s                  mem_resp_o,
   input  logic                                  mem_resp_v_o,
   input  logic                                  mem_resp_yumi_i,
   input  logic [bp2wb_pkg::addr_width_lp-1:0]   wbm_adr_o,
   input  logic [bp2wb_pkg::data_width_lp-1:0]   wbm_dat_o,
   input  logic [bp2wb_pkg::sel_width_lp-1:0]    wbm_sel_o,
   input  logic                                  wbm_we_o,
   input  logic                                  wbm_stb_o,
   input  logic                                  wbm_ack_i,
   input  logic                                  wbm_err_i
);

   // Cycle held with frozen outputs until the slave ends it
   bus_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (wbm_stb_o && !wbm_ack_i && !wbm_err_i) |=>
         (wbm_stb_o && $stable(wbm_adr_o) && $stable(wbm_dat_o)
          && $stable(wbm_sel_o) && $stable(wbm_we_o)))
      else $error("stb dropped or bus outputs moved before ack or err");

   // Yumi only against a valid response
   yumi_valid_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mem_resp_yumi_i |-> mem_resp_v_o)
      else $error("yumi high without a valid response");

   // Pending response frozen
   resp_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (mem_resp_v_o && !mem_resp_yumi_i) |=> (mem_resp_v_o && $stable(mem_resp_o)))
      else $error("response changed or vanished before yumi");

   // Empty buffer out of reset
   ready_reset_a: assert property (@(posedge clk_i)
      !rst_n_i |=> mem_cmd_ready_o)
      else $error("command ready low right after reset");

endmodule

bind bp2wb_bridge bp2wb_chk u_chk
(
   .clk_i            (clk_i),
   .rst_n_i          (rst_n_i),
   .mem_cmd_ready_o  (mem_cmd_ready_o),
   .mem_resp_o       (mem_resp_o),
   .mem_resp_v_o     (mem_resp_v_o),
   .mem_resp_yumi_i  (mem_resp_yumi_i),
   .wbm_adr_o        (wbm_adr_o),
   .wbm_dat_o        (wbm_dat_o),
   .wbm_sel_o        (wbm_sel_o),
   .wbm_we_o         (wbm_we_o),
   .wbm_stb_o        (wbm_stb_o),
   .wbm_ack_i        (wbm_ack_i),
   .wbm_err_i        (wbm_err_i)
);

//--- tests/tb_bp2wb.sv
////////////////////////////////////////
// bp2wb bridge testbench
// Command table against a Wishbone
// slave memory with random wait states
////////////////////////////////////////
module tb_bp2wb;

   typedef struct packed
   {
      bp2wb_pkg::mem_cmd_s    cmd;
      bp2wb_pkg::mem_resp_s   resp;
      int                     yumi_dly;
   } entry_s;

   localparam int reset_cycles_lp = 16;
   localparam int mem_words_lp    = 256;
   // First word index that answers with err
   localparam int err_word_lp     = 240;

   logic                                  clk_i           = 1'b0;
   logic                                  rst_n_i         = 1'b0;
   bp2wb_pkg::mem_cmd_s                   mem_cmd_i       = '0;
   logic                                  mem_cmd_v_i     = 1'b0;
   logic                                  mem_cmd_ready_o;
   bp2wb_pkg::mem_resp_s                  mem_resp_o;
   logic                                  mem_resp_v_o;
   logic                                  mem_resp_yumi_i = 1'b0;
   logic [bp2wb_pkg::addr_width_lp-1:0]   wbm_adr_o;
   logic [bp2wb_pkg::data_width_lp-1:0]   wbm_dat_o;
   logic [bp2wb_pkg::sel_width_lp-1:0]    wbm_sel_o;
   logic                                  wbm_we_o;
   logic                                  wbm_stb_o;
   logic                                  wbm_cyc_o;
   logic [bp2wb_pkg::data_width_lp-1:0]   wbm_dat_i       = '0;
   logic                                  wbm_ack_i       = 1'b0;
   logic                                  wbm_err_i       = 1'b0;

   entry_s                                table_q [$];
   bp2wb_pkg::wb_req_s                    bus_q [$];
   logic [63:0]                           shadow [mem_words_lp];
   logic [63:0]                           mem [mem_words_lp];
   int                                    seed        = 32'h036e_d0fd;
   int                                    cycle_cnt   = 0;
   int                                    cycle_limit = 0;
   int                                    bus_idx     = 0;
   int                                    wait_cnt    = 0;
   int                                    draw;
   logic                                  started     = 1'b0;
   logic                                  cyc_prev    = 1'b0;
   logic                                  ready_fell  = 1'b0;

   bp2wb_bridge u_dut (.*);

   always #4 clk_i = ~clk_i;

   function automatic logic [63:0] fill_word(int idx);
      return {32'hc0de_0000 | idx, idx ^ 32'h5a5a_5a5a};
   endfunction

   task automatic fail_run(string why);
      $display("%s", why);
      $display("test failed");
      $fatal(1, "run stopped");
   endtask

   task automatic value_error(string name, logic [63:0] exp, logic [63:0] act);
      $display("** Error at time %0t: %s expected %h, got %h", $time, name, exp, act);
      $display("test failed");
      $fatal(1, "value mismatch");
   endtask

   task automatic check_resp(bp2wb_pkg::mem_resp_s exp, bp2wb_pkg::mem_resp_s act);
      if (act.opcode !== exp.opcode)
         value_error("mem_resp_o.opcode", 64'(exp.opcode), 64'(act.opcode));
      if (act.size !== exp.size)
         value_error("mem_resp_o.size", 64'(exp.size), 64'(act.size));
      if (act.addr !== exp.addr)
         value_error("mem_resp_o.addr", 64'(exp.addr), 64'(act.addr));
      if (act.data !== exp.data)
         value_error("mem_resp_o.data", exp.data, act.data);
      if (act.err !== exp.err)
         value_error("mem_resp_o.err", 64'(exp.err), 64'(act.err));
   endtask

   task automatic check_wb(bp2wb_pkg::wb_req_s exp, bp2wb_pkg::wb_req_s act);
      if (act.adr !== exp.adr)
         value_error("wbm_adr_o", 64'(exp.adr), 64'(act.adr));
      if (act.sel !== exp.sel)
         value_error("wbm_sel_o", 64'(exp.sel), 64'(act.sel));
      if (act.we !== exp.we)
         value_error("wbm_we_o", 64'(exp.we), 64'(act.we));
      // dat_o only means something on writes
      if (exp.we && act.dat !== exp.dat)
         value_error("wbm_dat_o", exp.dat, act.dat);
   endtask

   function automatic bp2wb_pkg::wb_req_s sample_bus();
      bp2wb_pkg::wb_req_s seen;
      seen     = '0;
      seen.adr = wbm_adr_o;
      seen.dat = wbm_dat_o;
      seen.sel = wbm_sel_o;
      seen.we  = wbm_we_o;
      return seen;
   endfunction

   // Bus fields expected for an aligned command, one byte lane at a time
   function automatic bp2wb_pkg::wb_req_s expected_bus(bp2wb_pkg::mem_cmd_s cmd);
      bp2wb_pkg::wb_req_s req;
      int                 nbytes;
      int                 off;
      req    = '0;
      nbytes = 1 << cmd.size;
      off    = int'(cmd.addr[2:0]);
      req.adr = {cmd.addr[bp2wb_pkg::addr_width_lp-1:3], 3'b000};
      req.we  = (cmd.opcode == bp2wb_pkg::e_mem_wr);
      for (int b = 0; b < nbytes; b++)
      begin
         req.sel[off + b] = 1'b1;
         if (req.we)
            req.dat[(off + b) * 8 +: 8] = cmd.data[b * 8 +: 8];
      end
      return req;
   endfunction

   // Expected response from the shadow memory, which tracks every good write
   task automatic add_entry(bp2wb_pkg::mem_opcode_e op, bp2wb_pkg::mem_size_e size,
                            int word, int off, logic [63:0] data, int dly);
      entry_s e;
      int     nbytes;
      logic   bad;
      e      = '0;
      nbytes = 1 << size;
      bad    = (off % nbytes) != 0;
      e.cmd.opcode  = op;
      e.cmd.size    = size;
      e.cmd.addr    = (37'(word) << 3) | 37'(off);
      // Bytes past the size are junk for the bridge to drop
      e.cmd.data    = data;
      e.resp.opcode = op;
      e.resp.size   = size;
      e.resp.addr   = e.cmd.addr;
      e.resp.err    = bad || (word >= err_word_lp);
      if (!e.resp.err)
      begin
         for (int b = 0; b < nbytes; b++)
         begin
            if (op == bp2wb_pkg::e_mem_wr)
               shadow[word][(off + b) * 8 +: 8] = data[b * 8 +: 8];
            else
               e.resp.data[b * 8 +: 8] = shadow[word][(off + b) * 8 +: 8];
         end
      end
      e.yumi_dly = dly;
      table_q.push_back(e);
      // No bus cycle for misaligned commands
      if (!bad)
         bus_q.push_back(expected_bus(e.cmd));
   endtask

   task automatic build_table();
      int word;
      int size;
      int off;
      for (int i = 0; i < mem_words_lp; i++)
         shadow[i] = fill_word(i);
      // Every size at every aligned offset, write then read back
      word = 16;
      for (int s = 0; s < 4; s++)
      begin
         for (int o = 0; o < 8; o += (1 << s))
         begin
            add_entry(bp2wb_pkg::e_mem_wr, bp2wb_pkg::mem_size_e'(s), word, o,
                      {$random(seed), $random(seed)}, 0);
            add_entry(bp2wb_pkg::e_mem_rd, bp2wb_pkg::mem_size_e'(s), word, o, '0, 0);
            word++;
         end
      end
      // Misaligned
      add_entry(bp2wb_pkg::e_mem_wr, bp2wb_pkg::e_size_2, 40, 1, 64'h1122_3344_5566_7788, 0);
      add_entry(bp2wb_pkg::e_mem_rd, bp2wb_pkg::e_size_4, 40, 2, '0, 0);
      add_entry(bp2wb_pkg::e_mem_wr, bp2wb_pkg::e_size_8, 40, 4, 64'hdead_beef_cafe_f00d, 0);
      add_entry(bp2wb_pkg::e_mem_rd, bp2wb_pkg::e_size_2, 40, 7, '0, 0);
      // Error window, then a normal read
      add_entry(bp2wb_pkg::e_mem_wr, bp2wb_pkg::e_size_8, 240, 0, 64'h0bad_0bad_0bad_0bad, 0);
      add_entry(bp2wb_pkg::e_mem_rd, bp2wb_pkg::e_size_4, 250, 4, '0, 0);
      add_entry(bp2wb_pkg::e_mem_rd, bp2wb_pkg::e_size_1, 255, 3, '0, 0);
      add_entry(bp2wb_pkg::e_mem_rd, bp2wb_pkg::e_size_8, 16, 0, '0, 0);
      // Random pairs under slow yumi
      for (int i = 0; i < 20; i++)
      begin
         size = $random(seed) & 3;
         word = 64 + ($random(seed) & 127);
         off  = (($random(seed) & 7) >> size) << size;
         add_entry(bp2wb_pkg::e_mem_wr, bp2wb_pkg::mem_size_e'(size), word, off,
                   {$random(seed), $random(seed)}, ($random(seed) & 32'h7fff_ffff) % 11);
         add_entry(bp2wb_pkg::e_mem_rd, bp2wb_pkg::mem_size_e'(size), word, off, '0,
                   ($random(seed) & 32'h7fff_ffff) % 11);
      end
   endtask

   // Slave answer on the current cycle
   task automatic answer_cycle();
      logic [33:0] word_idx;
      int          idx;
      word_idx = wbm_adr_o[bp2wb_pkg::addr_width_lp-1:3];
      if (word_idx >= 34'(err_word_lp))
         wbm_err_i <= 1'b1;
      else
      begin
         idx = int'(word_idx[7:0]);
         wbm_ack_i <= 1'b1;
         wbm_dat_i <= mem[idx];
         if (wbm_we_o)
         begin
            for (int b = 0; b < 8; b++)
               if (wbm_sel_o[b])
                  mem[idx][b * 8 +: 8] <= wbm_dat_o[b * 8 +: 8];
         end
      end
   endtask

   // Wishbone slave, 0 to 3 wait states per cycle
   always @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         wbm_ack_i <= 1'b0;
         wbm_err_i <= 1'b0;
         wbm_dat_i <= '0;
         started   <= 1'b0;
         for (int i = 0; i < mem_words_lp; i++)
            mem[i] <= fill_word(i);
      end
      else if (wbm_ack_i || wbm_err_i)
      begin
         wbm_ack_i <= 1'b0;
         wbm_err_i <= 1'b0;
         started   <= 1'b0;
      end
      else if (wbm_cyc_o && wbm_stb_o)
      begin
         if (!started)
         begin
            draw = $random(seed) & 3;
            started  <= 1'b1;
            wait_cnt <= draw;
            // No wait states, answer on the first edge
            if (draw == 0)
               answer_cycle();
         end
         else if (wait_cnt > 1)
            wait_cnt <= wait_cnt - 1;
         else
            answer_cycle();
      end
   end

   // Bus monitor, checks fields at cyc rise
   always @(posedge clk_i)
   begin
      cyc_prev <= wbm_cyc_o;
      if (rst_n_i && !mem_cmd_ready_o)
         ready_fell <= 1'b1;
      // Classic cycles keep stb and cyc together
      if (rst_n_i && wbm_stb_o !== wbm_cyc_o)
         value_error("wbm_stb_o", 64'(wbm_cyc_o), 64'(wbm_stb_o));
      if (rst_n_i && wbm_cyc_o && !cyc_prev)
      begin
         if (bus_idx >= bus_q.size())
            fail_run("A bus cycle started with no aligned command outstanding");
         else
            check_wb(bus_q[bus_idx], sample_bus());
         bus_idx <= bus_idx + 1;
      end
   end

   always @(posedge clk_i)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit != 0 && cycle_cnt > cycle_limit)
         fail_run("The run did not finish within its cycle limit");
   end

   task automatic drive_commands();
      for (int i = 0; i < table_q.size(); i++)
      begin
         mem_cmd_i   <= table_q[i].cmd;
         mem_cmd_v_i <= 1'b1;
         @(posedge clk_i);
         // Hold until the bridge takes it
         while (!mem_cmd_ready_o)
            @(posedge clk_i);
      end
      mem_cmd_v_i <= 1'b0;
   endtask

   task automatic take_responses();
      for (int i = 0; i < table_q.size(); i++)
      begin
         @(posedge clk_i);
         while (!mem_resp_v_o)
            @(posedge clk_i);
         repeat (table_q[i].yumi_dly)
            @(posedge clk_i);
         check_resp(table_q[i].resp, mem_resp_o);
         mem_resp_yumi_i <= 1'b1;
         @(posedge clk_i);
         mem_resp_yumi_i <= 1'b0;
      end
   endtask

   initial
   begin
      build_table();
      cycle_limit = 40 * table_q.size() + reset_cycles_lp;
      repeat (reset_cycles_lp) @(posedge clk_i);
      rst_n_i <= 1'b1;
      fork
         drive_commands();
         take_responses();
      join
      if (bus_idx != bus_q.size())
         fail_run("Fewer bus cycles ran than aligned commands were sent");
      else if (!ready_fell)
         fail_run("Command ready never fell while the buffers were full");
      else
      begin
         $display("test passed");
         $finish;
      end
   end

endmodule

//--- compile.f
hw/bp2wb_pkg.sv
hw/bp2wb_decode.sv
hw/bp2wb_execute.sv
hw/bp2wb_result.sv
hw/bp2wb_bridge.sv
tests/bp2wb_chk.sv
tests/tb_bp2wb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_bp2wb
FILELIST = compile.f

OBJ_DIR  = obj_dir
SIM      = $(OBJ_DIR)/V$(TOP)
SRCS     = $(wildcard hw/*.sv tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulator's own exit status is not trusted; the pass line decides
run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'test passed'

clean:
	rm -rf $(OBJ_DIR)
